//--- src.f
+incdir+sim
common/mips_isa_pkg.sv
common/decode_pkg.sv
decode/main_ctrl_dec.sv
decode/unit_ctrl_dec.sv
decode/operand_use_dec.sv
logic/id_pipe_reg.sv
logic/id_stage.sv
sim/id_stage_tb.sv

//--- sim/decode_ref.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// expected control bundle for one instruction word, one instruction class at a time
function automatic id_ctrl_t decode_expected(input logic [31:0] iw);
	logic [5:0] op;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] sa;
	logic [5:0] fn;
	logic       legal;
	logic       zext;
	id_ctrl_t   e;
	op = iw[31:26];
	rs = iw[25:21];
	rt = iw[20:16];
	sa = iw[10:6];
	fn = iw[5:0];
	legal = 1'b1;
	// andi, ori, xori, lui
	zext = (op >= 6'h0c) && (op <= 6'h0f);
	e = '0;
	e.main.alu_op = op_none;
	e.main.wb_dst = dst_rd;
	e.main.sign_ext = !zext;

	if (op == 6'h00) begin
		e.main.alu_op = op_rtype;
		case (fn)
			6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
			6'h2a, 6'h2b, 6'h04, 6'h07, 6'h06, 6'h0a, 6'h0b: begin
				e.main.reg_write = 1'b1;
				e.opnd = 2'b11;
				if (fn == 6'h06 && sa[0])
					e.main.alu_op = op_rotrv;
			end
			6'h00, 6'h02, 6'h03: begin
				e.main.reg_write = 1'b1;
				e.opnd.read_rt = 1'b1;
				if (fn == 6'h02 && rs[0])
					e.main.alu_op = op_rotr;
			end
			6'h08: e.opnd.read_rs = 1'b1;
			6'h09: begin
				e.main.reg_write = 1'b1;
				e.opnd.read_rs = 1'b1;
			end
			6'h10, 6'h12: begin
				e.main.reg_write = 1'b1;
				e.unit.hilo_read = 1'b1;
			end
			6'h11, 6'h13: begin
				e.opnd.read_rs = 1'b1;
				e.unit.hilo_write = 1'b1;
			end
			6'h18, 6'h19, 6'h1a, 6'h1b: begin
				e.opnd = 2'b11;
				e.unit.muldiv_en = 1'b1;
			end
			6'h0c: e.unit.syscall = 1'b1;
			6'h0d: e.unit.brk = 1'b1;
			default: legal = 1'b0;
		endcase
	end else if (op >= 6'h08 && op <= 6'h0f) begin
		e.main.reg_write = 1'b1;
		e.main.wb_dst = dst_rt;
		e.main.is_imm = 1'b1;
		e.opnd.read_rs = (op != 6'h0f);
		case (op[2:0])
			3'd0: e.main.alu_op = op_addi;
			3'd1: e.main.alu_op = op_addiu;
			3'd2: e.main.alu_op = op_slti;
			3'd3: e.main.alu_op = op_sltiu;
			3'd4: e.main.alu_op = op_andi;
			3'd5: e.main.alu_op = op_ori;
			3'd6: e.main.alu_op = op_xori;
			default: e.main.alu_op = op_lui;
		endcase
	end else if (op inside {6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h30}) begin
		e.main.alu_op = op_mem;
		e.main.reg_write = 1'b1;
		e.main.wb_dst = dst_rt;
		e.main.is_imm = 1'b1;
		e.main.mem_read = 1'b1;
		e.main.mem_to_reg = 1'b1;
		e.main.single_issue = 1'b1;
		e.opnd.read_rs = 1'b1;
	end else if (op inside {6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e}) begin
		e.main.alu_op = op_mem;
		e.main.is_imm = 1'b1;
		e.main.mem_write = 1'b1;
		e.main.single_issue = 1'b1;
		e.opnd = 2'b11;
	end else begin
		case (op)
			6'h02: legal = 1'b1;
			6'h03: begin
				e.main.reg_write = 1'b1;
				e.main.wb_dst = dst_ra;
			end
			6'h04, 6'h05: begin
				e.unit.branch_cond = (op == 6'h04) ? br_eq : br_ne;
				e.opnd = 2'b11;
			end
			6'h06, 6'h07: begin
				e.unit.branch_cond = (op == 6'h06) ? br_lez : br_gtz;
				e.opnd.read_rs = 1'b1;
			end
			6'h01: begin
				if (rt == 5'h00 || rt == 5'h01 || rt == 5'h10 || rt == 5'h11) begin
					e.unit.branch_cond = rt[0] ? br_gez : br_ltz;
					e.opnd.read_rs = 1'b1;
					// link forms write ra
					e.main.reg_write = rt[4];
					e.main.wb_dst = rt[4] ? dst_ra : dst_rd;
				end else begin
					legal = 1'b0;
				end
			end
			6'h10: begin
				e.main.single_issue = 1'b1;
				if (rs == 5'h04) begin
					e.main.alu_op = op_mtc0;
					e.unit.cp0_write = 1'b1;
					e.opnd.read_rt = 1'b1;
				end else if (rs == 5'h00) begin
					e.main.alu_op = op_mfc0;
					e.main.reg_write = 1'b1;
					e.main.wb_dst = dst_rt;
					e.main.is_mfc = 1'b1;
					e.unit.cp0_read = 1'b1;
				end else if (iw[25:0] == 26'h200_0018) begin
					e.unit.eret = 1'b1;
				end else begin
					legal = 1'b0;
				end
			end
			6'h1c: begin
				case (fn)
					6'h02: begin
						e.main.alu_op = op_mul;
						e.main.reg_write = 1'b1;
						e.unit.muldiv_en = 1'b1;
						e.opnd = 2'b11;
					end
					6'h00, 6'h01, 6'h04, 6'h05: begin
						e.main.alu_op = (fn == 6'h00) ? op_madd :
							(fn == 6'h01) ? op_maddu :
							(fn == 6'h04) ? op_msub : op_msubu;
						e.unit.muldiv_en = 1'b1;
						e.unit.hilo_read = 1'b1;
						e.unit.hilo_write = 1'b1;
						e.opnd = 2'b11;
					end
					6'h20, 6'h21: begin
						e.main.alu_op = (fn == 6'h20) ? op_clz : op_clo;
						e.main.reg_write = 1'b1;
						e.opnd.read_rs = 1'b1;
					end
					default: legal = 1'b0;
				endcase
			end
			default: legal = 1'b0;
		endcase
	end

	// reserved clears everything, cop0 stays single issue
	if (!legal) begin
		e = '0;
		e.main.alu_op = op_none;
		e.main.wb_dst = dst_rd;
		e.main.sign_ext = !zext;
		e.main.reserved = 1'b1;
		e.main.single_issue = (op == 6'h10);
	end
	return e;
endfunction

`endif

//--- sim/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb
	import mips_isa_pkg::*, decode_pkg::*;
();

	localparam logic [2:0] G_LATENCY  = 3'd0;
	localparam logic [2:0] G_SPECIAL  = 3'd1;
	localparam logic [2:0] G_OPCODE   = 3'd2;
	localparam logic [2:0] G_REGIMM   = 3'd3;
	localparam logic [2:0] G_SPECIAL2 = 3'd4;
	localparam logic [2:0] G_COP0     = 3'd5;
	localparam logic [2:0] G_RANDOM   = 3'd6;
	localparam logic [2:0] G_FLOW     = 3'd7;

	typedef struct packed {
		logic [31:0] word;
		logic [2:0]  grp;
	} stim_t;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [2:0]  grp;
	} pending_t;

	logic        clk;
	logic        rst;
	logic        in_valid;
	logic        in_ready;
	logic [31:0] instr;
	logic [31:0] pc;
	logic        out_valid;
	logic        out_ready;
	id_ctrl_t    ctrl;
	logic [31:0] out_pc;

	integer      seed;
	logic        random_flow;
	logic        ready_draw;
	logic [2:0]  cur_grp;
	stim_t       stim_q[$];
	pending_t    exp_q[$];
	pending_t    got;
	int          out_count;
	int          cycle_count;
	int          cycle_limit;

	`include "decode_ref.svh"

	id_stage #(
		.PC_W(32)
	) id_stage_i (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.instr    (instr),
		.pc       (pc),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.ctrl     (ctrl),
		.out_pc   (out_pc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic string group_name(input logic [2:0] grp);
		case (grp)
			G_LATENCY:  return "reset_latency";
			G_SPECIAL:  return "special_funct";
			G_OPCODE:   return "major_opcode";
			G_REGIMM:   return "regimm_branch";
			G_SPECIAL2: return "special2_funct";
			G_COP0:     return "cop0_access";
			G_RANDOM:   return "random_word";
			default:    return "random_flow";
		endcase
	endfunction

	task automatic check_value(input string test, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s expected %h actual %h", test, expected, actual);
			$display("Something failed");
			$fatal(1, "value mismatch in %s", test);
		end
	endtask

	task automatic add_test(input logic [31:0] word, input logic [2:0] grp);
		stim_q.push_back({word, grp});
	endtask

	// directed sweeps over every selector field with random bits elsewhere
	task automatic build_tests();
		logic [31:0] w;
		for (int f = 0; f < 64; f++) begin
			for (int k = 0; k < 2; k++) begin
				w = $random(seed);
				w[31:26] = 6'h00;
				w[5:0] = f[5:0];
				// rotate select bits for srl and srlv
				w[21] = k[0];
				w[6] = k[0];
				add_test(w, G_SPECIAL);
			end
		end
		for (int o = 0; o < 64; o++) begin
			for (int k = 0; k < 2; k++) begin
				w = $random(seed);
				w[31:26] = o[5:0];
				add_test(w, G_OPCODE);
			end
		end
		for (int r = 0; r < 32; r++) begin
			w = $random(seed);
			w[31:26] = 6'h01;
			w[20:16] = r[4:0];
			add_test(w, G_REGIMM);
		end
		for (int f = 0; f < 64; f++) begin
			w = $random(seed);
			w[31:26] = 6'h1c;
			w[5:0] = f[5:0];
			add_test(w, G_SPECIAL2);
		end
		for (int r = 0; r < 32; r++) begin
			w = $random(seed);
			w[31:26] = 6'h10;
			w[25:21] = r[4:0];
			add_test(w, G_COP0);
		end
		// eret and then eret with one stray bit
		add_test(32'h4200_0018, G_COP0);
		add_test(32'h4200_0019, G_COP0);
		for (int n = 0; n < 64; n++) begin
			w = $random(seed);
			add_test(w, G_RANDOM);
		end
	endtask

	// called at a falling edge and returns at the falling edge after the transfer
	task automatic send_instr(input logic [31:0] word, input logic [2:0] grp);
		logic accepted;
		in_valid = 1'b1;
		instr = word;
		cur_grp = grp;
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge clk);
			accepted = in_ready;
		end
		@(negedge clk);
		pc = pc + 32'd4;
	endtask

	// out_ready value for the next falling edge
	always @(posedge clk) begin
		if (random_flow)
			ready_draw = (($random(seed) & 3) != 0);
	end

	always @(negedge clk) begin
		if (random_flow)
			out_ready <= ready_draw;
		else
			out_ready <= 1'b1;
	end

	// pop on every output transfer and push on every accepted input
	always @(posedge clk) begin
		if (!rst) begin
			// the register holds an entry exactly while one is outstanding
			check_value("handshake out_valid", exp_q.size() != 0, out_valid);
			check_value("handshake in_ready", exp_q.size() == 0 || out_ready, in_ready);
		end
		if (!rst && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				$display("the DUT delivered an instruction that was never accepted");
				$display("Something failed");
				$fatal(1, "output transfer with empty scoreboard");
			end else begin
				got = exp_q.pop_front();
				check_value(group_name(got.grp), decode_expected(got.instr), ctrl);
				check_value($sformatf("%s pc", group_name(got.grp)), got.pc, out_pc);
				out_count = out_count + 1;
			end
		end
		if (!rst && in_valid && in_ready)
			exp_q.push_back({instr, pc, cur_grp});
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
			$display("Something failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		seed = 32'ha21f716d;
		rst = 1'b1;
		in_valid = 1'b0;
		instr = '0;
		pc = 32'h0040_0000;
		out_ready = 1'b0;
		random_flow = 1'b0;
		ready_draw = 1'b1;
		cur_grp = G_LATENCY;
		out_count = 0;
		cycle_count = 0;
		build_tests();
		// one directed pass and one random pass plus the latency probe
		cycle_limit = 4 * (2 * stim_q.size() + 1) + 200;

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_value("reset_latency", 64'd0, out_valid);
		// add $3, $1, $2
		send_instr(32'h0022_1820, G_LATENCY);
		check_value("reset_latency", 64'd1, out_valid);

		foreach (stim_q[i])
			send_instr(stim_q[i].word, stim_q[i].grp);

		random_flow = 1'b1;
		foreach (stim_q[i]) begin
			while (($random(seed) & 3) == 0) begin
				in_valid = 1'b0;
				@(negedge clk);
			end
			send_instr(stim_q[i].word, G_FLOW);
		end
		in_valid = 1'b0;

		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);

		if (exp_q.size() == 0 && out_count == 2 * stim_q.size() + 1) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("%0d instructions came out, %0d were sent", out_count,
				2 * stim_q.size() + 1);
			$display("Something failed");
			$fatal(1, "instruction count mismatch");
		end
	end

endmodule

//--- logic/id_stage.sv
`timescale 1ns/1ps

module id_stage
	import mips_isa_pkg::*, decode_pkg::*;
#(
	parameter int PC_W = 32
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               in_valid,
	output logic               in_ready,
	input  logic [INSTR_W-1:0] instr,
	input  logic [PC_W-1:0]    pc,
	output logic               out_valid,
	input  logic               out_ready,
	output id_ctrl_t           ctrl,
	output logic [PC_W-1:0]    out_pc
);

	instr_fields_t fields;
	main_ctrl_t    main_c;
	unit_ctrl_t    unit_c;
	operand_use_t  opnd_c;
	id_ctrl_t      ctrl_d;

	assign fields = instr;

	main_ctrl_dec main_ctrl_dec_i (
		.fields(fields),
		.ctrl  (main_c)
	);

	unit_ctrl_dec unit_ctrl_dec_i (
		.fields(fields),
		.ctrl  (unit_c)
	);

	operand_use_dec operand_use_dec_i (
		.fields  (fields),
		.opnd_use(opnd_c)
	);

	assign ctrl_d.main = main_c;
	assign ctrl_d.unit = unit_c;
	assign ctrl_d.opnd = opnd_c;

	id_pipe_reg #(
		.PC_W(PC_W)
	) id_pipe_reg_i (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.ctrl_in  (ctrl_d),
		.pc_in    (pc),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.ctrl_out (ctrl),
		.pc_out   (out_pc)
	);

endmodule

//--- logic/id_pipe_reg.sv
`timescale 1ns/1ps

module id_pipe_reg
	import decode_pkg::*;
#(
	parameter int PC_W = 32
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            in_valid,
	output logic            in_ready,
	input  id_ctrl_t        ctrl_in,
	input  logic [PC_W-1:0] pc_in,
	output logic            out_valid,
	input  logic            out_ready,
	output id_ctrl_t        ctrl_out,
	output logic [PC_W-1:0] pc_out
);

	// empty, or the held entry leaves this cycle
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			ctrl_out <= ctrl_in;
			pc_out <= pc_in;
		end
	end

endmodule

//--- decode/operand_use_dec.sv
`timescale 1ns/1ps

module operand_use_dec
	import mips_isa_pkg::*, decode_pkg::*;
(
	input  instr_fields_t fields,
	output operand_use_t  opnd_use
);

	always_comb begin
		opnd_use = '0;
		case (fields.op)
			opc_special: begin
				case (fields.funct)
					fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu,
					fn_and, fn_or, fn_xor, fn_nor,
					fn_sllv, fn_srav, fn_srlv, fn_movn, fn_movz,
					fn_mult, fn_multu, fn_div, fn_divu: begin
						opnd_use.read_rs = 1'b1;
						opnd_use.read_rt = 1'b1;
					end
					// fixed shifts, rotr included
					fn_sll, fn_srl, fn_sra: opnd_use.read_rt = 1'b1;
					fn_jr, fn_jalr, fn_mthi, fn_mtlo: opnd_use.read_rs = 1'b1;
					default: opnd_use = '0;
				endcase
			end
			opc_beq, opc_bne, opc_sw, opc_sb, opc_sh, opc_swl, opc_swr: begin
				opnd_use.read_rs = 1'b1;
				opnd_use.read_rt = 1'b1;
			end
			opc_addi, opc_addiu, opc_slti, opc_sltiu, opc_andi, opc_ori, opc_xori,
			opc_lw, opc_lb, opc_lbu, opc_lh, opc_lhu, opc_lwl, opc_lwr, opc_ll,
			opc_blez, opc_bgtz: begin
				opnd_use.read_rs = 1'b1;
			end
			opc_regimm: begin
				opnd_use.read_rs = fields.rt inside {ri_bltz, ri_bgez, ri_bltzal, ri_bgezal};
			end
			opc_cop0: begin
				opnd_use.read_rt = (fields.rs == c0_mtc0);
			end
			opc_special2: begin
				case (fields.funct)
					s2_mul, s2_madd, s2_maddu, s2_msub, s2_msubu: begin
						opnd_use.read_rs = 1'b1;
						opnd_use.read_rt = 1'b1;
					end
					s2_clo, s2_clz: opnd_use.read_rs = 1'b1;
					default: opnd_use = '0;
				endcase
			end
			// lui, j, jal and reserved read nothing
			default: opnd_use = '0;
		endcase
	end

endmodule

//--- decode/unit_ctrl_dec.sv
`timescale 1ns/1ps

module unit_ctrl_dec
	import mips_isa_pkg::*, decode_pkg::*;
(
	input  instr_fields_t fields,
	output unit_ctrl_t    ctrl
);

	logic [25:0] tail;
	logic        is_special;
	logic        is_special2;
	logic        is_cop0;
	logic        is_madd_form;

	assign tail = {fields.rs, fields.rt, fields.rd, fields.shamt, fields.funct};
	assign is_special = (fields.op == opc_special);
	assign is_special2 = (fields.op == opc_special2);
	assign is_cop0 = (fields.op == opc_cop0);
	// accumulate forms both read and write hi/lo
	assign is_madd_form = is_special2 &&
		(fields.funct inside {s2_madd, s2_maddu, s2_msub, s2_msubu});

	always_comb begin
		ctrl = '0;
		case (fields.op)
			opc_beq:  ctrl.branch_cond = br_eq;
			opc_bne:  ctrl.branch_cond = br_ne;
			opc_blez: ctrl.branch_cond = br_lez;
			opc_bgtz: ctrl.branch_cond = br_gtz;
			opc_regimm: begin
				case (fields.rt)
					ri_bltz, ri_bltzal: ctrl.branch_cond = br_ltz;
					ri_bgez, ri_bgezal: ctrl.branch_cond = br_gez;
					default:            ctrl.branch_cond = br_none;
				endcase
			end
			default: ctrl.branch_cond = br_none;
		endcase

		if (is_special)
			ctrl.muldiv_en = fields.funct inside {fn_mult, fn_multu, fn_div, fn_divu};
		else if (is_special2)
			ctrl.muldiv_en = (fields.funct == s2_mul) || is_madd_form;

		ctrl.hilo_read = is_madd_form ||
			(is_special && (fields.funct inside {fn_mfhi, fn_mflo}));
		ctrl.hilo_write = is_madd_form ||
			(is_special && (fields.funct inside {fn_mthi, fn_mtlo}));

		ctrl.cp0_write = is_cop0 && (fields.rs == c0_mtc0);
		ctrl.cp0_read = is_cop0 && (fields.rs == c0_mfc0);
		ctrl.eret = is_cop0 && (tail == ERET_WORD);

		ctrl.syscall = is_special && (fields.funct == fn_syscall);
		ctrl.brk = is_special && (fields.funct == fn_break);
	end

endmodule

//--- decode/main_ctrl_dec.sv
`timescale 1ns/1ps

module main_ctrl_dec
	import mips_isa_pkg::*, decode_pkg::*;
(
	input  instr_fields_t fields,
	output main_ctrl_t    ctrl
);

	logic [25:0] tail;

	assign tail = {fields.rs, fields.rt, fields.rd, fields.shamt, fields.funct};

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = op_none;
		ctrl.wb_dst = dst_rd;
		// logical immediates and lui zero-extend
		ctrl.sign_ext = !(fields.op inside {opc_andi, opc_ori, opc_xori, opc_lui});

		case (fields.op)
			opc_special: begin
				ctrl.alu_op = op_rtype;
				case (fields.funct)
					fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu,
					fn_and, fn_or, fn_xor, fn_nor,
					fn_sll, fn_sra, fn_sllv, fn_srav,
					fn_movn, fn_movz, fn_mfhi, fn_mflo, fn_jalr: begin
						ctrl.reg_write = 1'b1;
					end
					fn_srl: begin
						ctrl.reg_write = 1'b1;
						if (fields.rs[0])
							ctrl.alu_op = op_rotr;
					end
					fn_srlv: begin
						ctrl.reg_write = 1'b1;
						if (fields.shamt[0])
							ctrl.alu_op = op_rotrv;
					end
					// no gpr write, handled by other units
					fn_jr, fn_mult, fn_multu, fn_div, fn_divu,
					fn_mthi, fn_mtlo, fn_syscall, fn_break: begin
						ctrl.reg_write = 1'b0;
					end
					default: begin
						ctrl.alu_op = op_none;
						ctrl.reserved = 1'b1;
					end
				endcase
			end
			opc_addi, opc_addiu, opc_slti, opc_sltiu,
			opc_andi, opc_ori, opc_xori, opc_lui: begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_dst = dst_rt;
				ctrl.is_imm = 1'b1;
				case (fields.op)
					opc_addi:  ctrl.alu_op = op_addi;
					opc_addiu: ctrl.alu_op = op_addiu;
					opc_slti:  ctrl.alu_op = op_slti;
					opc_sltiu: ctrl.alu_op = op_sltiu;
					opc_andi:  ctrl.alu_op = op_andi;
					opc_ori:   ctrl.alu_op = op_ori;
					opc_xori:  ctrl.alu_op = op_xori;
					default:   ctrl.alu_op = op_lui;
				endcase
			end
			opc_lw, opc_lb, opc_lbu, opc_lh, opc_lhu, opc_lwl, opc_lwr, opc_ll: begin
				ctrl.alu_op = op_mem;
				ctrl.reg_write = 1'b1;
				ctrl.wb_dst = dst_rt;
				ctrl.is_imm = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.single_issue = 1'b1;
			end
			opc_sw, opc_sb, opc_sh, opc_swl, opc_swr: begin
				ctrl.alu_op = op_mem;
				ctrl.is_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.single_issue = 1'b1;
			end
			opc_beq, opc_bne, opc_blez, opc_bgtz, opc_j: begin
				ctrl.reg_write = 1'b0;
			end
			opc_jal: begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_dst = dst_ra;
			end
			opc_regimm: begin
				case (fields.rt)
					ri_bltzal, ri_bgezal: begin
						ctrl.reg_write = 1'b1;
						ctrl.wb_dst = dst_ra;
					end
					ri_bltz, ri_bgez: begin
						ctrl.reg_write = 1'b0;
					end
					default: ctrl.reserved = 1'b1;
				endcase
			end
			opc_cop0: begin
				ctrl.single_issue = 1'b1;
				case (fields.rs)
					c0_mtc0: ctrl.alu_op = op_mtc0;
					c0_mfc0: begin
						ctrl.alu_op = op_mfc0;
						ctrl.reg_write = 1'b1;
						ctrl.wb_dst = dst_rt;
						ctrl.is_mfc = 1'b1;
					end
					// only eret is legal here
					default: ctrl.reserved = (tail != ERET_WORD);
				endcase
			end
			opc_special2: begin
				case (fields.funct)
					s2_mul: begin
						ctrl.alu_op = op_mul;
						ctrl.reg_write = 1'b1;
					end
					s2_clo: begin
						ctrl.alu_op = op_clo;
						ctrl.reg_write = 1'b1;
					end
					s2_clz: begin
						ctrl.alu_op = op_clz;
						ctrl.reg_write = 1'b1;
					end
					s2_madd:  ctrl.alu_op = op_madd;
					s2_maddu: ctrl.alu_op = op_maddu;
					s2_msub:  ctrl.alu_op = op_msub;
					s2_msubu: ctrl.alu_op = op_msubu;
					default:  ctrl.reserved = 1'b1;
				endcase
			end
			default: ctrl.reserved = 1'b1;
		endcase
	end

endmodule

//--- common/decode_pkg.sv
package decode_pkg;

	typedef enum logic [4:0] {
		op_rtype,
		op_rotr,
		op_rotrv,
		op_addi,
		op_addiu,
		op_slti,
		op_sltiu,
		op_andi,
		op_ori,
		op_xori,
		op_lui,
		op_mem,
		op_mtc0,
		op_mfc0,
		op_mul,
		op_madd,
		op_maddu,
		op_msub,
		op_msubu,
		op_clo,
		op_clz,
		op_none
	} alu_op_t;

	typedef enum logic [1:0] {
		dst_rd,
		dst_rt,
		dst_ra
	} wb_dst_t;

	typedef enum logic [2:0] {
		br_none,
		br_eq,
		br_ne,
		br_lez,
		br_gtz,
		br_ltz,
		br_gez
	} branch_cond_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic    reg_write;
		wb_dst_t wb_dst;
		logic    is_imm;
		logic    sign_ext;
		logic    mem_to_reg;
		logic    mem_read;
		logic    mem_write;
		logic    is_mfc;
		logic    single_issue;
		logic    reserved;
	} main_ctrl_t;

	typedef struct packed {
		branch_cond_t branch_cond;
		logic         muldiv_en;
		logic         hilo_read;
		logic         hilo_write;
		logic         cp0_read;
		logic         cp0_write;
		logic         eret;
		logic         syscall;
		logic         brk;
	} unit_ctrl_t;

	typedef struct packed {
		logic read_rs;
		logic read_rt;
	} operand_use_t;

	typedef struct packed {
		main_ctrl_t   main;
		unit_ctrl_t   unit;
		operand_use_t opnd;
	} id_ctrl_t;

endpackage

//--- common/mips_isa_pkg.sv
package mips_isa_pkg;

	parameter int INSTR_W    = 32;
	parameter int REG_ADDR_W = 5;

	// ERET is COP0 with CO set and funct 0x18, all other bits zero
	parameter logic [25:0] ERET_WORD = 26'h200_0018;

	typedef enum logic [5:0] {
		opc_special  = 6'h00,
		opc_regimm   = 6'h01,
		opc_j        = 6'h02,
		opc_jal      = 6'h03,
		opc_beq      = 6'h04,
		opc_bne      = 6'h05,
		opc_blez     = 6'h06,
		opc_bgtz     = 6'h07,
		opc_addi     = 6'h08,
		opc_addiu    = 6'h09,
		opc_slti     = 6'h0a,
		opc_sltiu    = 6'h0b,
		opc_andi     = 6'h0c,
		opc_ori      = 6'h0d,
		opc_xori     = 6'h0e,
		opc_lui      = 6'h0f,
		opc_cop0     = 6'h10,
		opc_special2 = 6'h1c,
		opc_lb       = 6'h20,
		opc_lh       = 6'h21,
		opc_lwl      = 6'h22,
		opc_lw       = 6'h23,
		opc_lbu      = 6'h24,
		opc_lhu      = 6'h25,
		opc_lwr      = 6'h26,
		opc_sb       = 6'h28,
		opc_sh       = 6'h29,
		opc_swl      = 6'h2a,
		opc_sw       = 6'h2b,
		opc_swr      = 6'h2e,
		opc_ll       = 6'h30
	} opcode_t;

	typedef enum logic [5:0] {
		fn_sll     = 6'h00,
		fn_srl     = 6'h02,
		fn_sra     = 6'h03,
		fn_sllv    = 6'h04,
		fn_srlv    = 6'h06,
		fn_srav    = 6'h07,
		fn_jr      = 6'h08,
		fn_jalr    = 6'h09,
		fn_movz    = 6'h0a,
		fn_movn    = 6'h0b,
		fn_syscall = 6'h0c,
		fn_break   = 6'h0d,
		fn_mfhi    = 6'h10,
		fn_mthi    = 6'h11,
		fn_mflo    = 6'h12,
		fn_mtlo    = 6'h13,
		fn_mult    = 6'h18,
		fn_multu   = 6'h19,
		fn_div     = 6'h1a,
		fn_divu    = 6'h1b,
		fn_add     = 6'h20,
		fn_addu    = 6'h21,
		fn_sub     = 6'h22,
		fn_subu    = 6'h23,
		fn_and     = 6'h24,
		fn_or      = 6'h25,
		fn_xor     = 6'h26,
		fn_nor     = 6'h27,
		fn_slt     = 6'h2a,
		fn_sltu    = 6'h2b
	} funct_t;

	typedef enum logic [5:0] {
		s2_madd  = 6'h00,
		s2_maddu = 6'h01,
		s2_mul   = 6'h02,
		s2_msub  = 6'h04,
		s2_msubu = 6'h05,
		s2_clz   = 6'h20,
		s2_clo   = 6'h21
	} special2_funct_t;

	typedef enum logic [4:0] {
		ri_bltz   = 5'h00,
		ri_bgez   = 5'h01,
		ri_bltzal = 5'h10,
		ri_bgezal = 5'h11
	} regimm_rt_t;

	typedef enum logic [4:0] {
		c0_mfc0 = 5'h00,
		c0_mtc0 = 5'h04,
		c0_co   = 5'h10
	} cop0_rs_t;

	// raw fields, compared against the enums above
	typedef struct packed {
		logic [5:0]            op;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [4:0]            shamt;
		logic [5:0]            funct;
	} instr_fields_t;

endpackage
